//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_bru
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
design/bru_pkg.sv
design/operand_stage.sv
design/branch_compare.sv
design/branch_unit.sv
design/bru_ctrl.sv
design/bru_top.sv
sim/tb_bru.sv

//--- design/branch_compare.sv
`timescale 1ns/1ps

module branch_compare import bru_pkg::*; #(
    parameter int unsigned VLEN = 32
) (
    // Operation and compare operands
    input  fu_data_t fu_data_i,
    // Branch condition, forced high for jumps
    output logic     comp_res_o
);

    logic [VLEN-1:0] op_a;
    logic [VLEN-1:0] op_b;
    logic            is_eq;
    logic            lt_signed;
    logic            lt_unsigned;

    // Only the low VLEN bits take part in the compare
    assign op_a = fu_data_i.operand_a[VLEN-1:0];
    assign op_b = fu_data_i.operand_b[VLEN-1:0];

    assign is_eq       = (op_a == op_b);
    assign lt_signed   = ($signed(op_a) < $signed(op_b));
    assign lt_unsigned = (op_a < op_b);

    always_comb begin
        case (fu_data_i.operation)
            BEQ: begin
                comp_res_o = is_eq;
            end
            BNE: begin
                comp_res_o = !is_eq;
            end
            BLT: begin
                comp_res_o = lt_signed;
            end
            // Greater-or-equal is the complement of less-than
            BGE: begin
                comp_res_o = !lt_signed;
            end
            BLTU: begin
                comp_res_o = lt_unsigned;
            end
            BGEU: begin
                comp_res_o = !lt_unsigned;
            end
            // JAL and JALR always jump
            default: begin
                comp_res_o = 1'b1;
            end
        endcase
    end

endmodule

//--- design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import bru_pkg::*; #(
    parameter int unsigned VLEN   = 32,
    parameter bit          RVC_EN = 1'b1
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // Execute-stage instruction
    input  logic            valid_i,
    input  issue_t          issue_i,
    // Condition from the comparator
    input  logic            comp_res_i,
    // Resolution back to the front end
    output bp_resolve_t     resolved_o,
    output logic            resolve_branch_o,
    // Return address for rd
    output logic [VLEN-1:0] link_o,
    output exception_t      exception_o,
    // Fetch must be redirected
    output logic            redirect_o
);

    logic            is_branch;
    logic            is_jalr;
    logic            jump_taken;
    logic [VLEN-1:0] pc;
    logic [VLEN-1:0] jump_base;
    logic [VLEN-1:0] target_address;
    logic [VLEN-1:0] next_pc;
    logic [VLEN-1:0] predict_address;

    assign pc              = issue_i.pc[VLEN-1:0];
    assign predict_address = issue_i.predict.predict_address[VLEN-1:0];
    assign is_jalr         = (issue_i.fu_data.operation == JALR);
    assign is_branch       = issue_i.fu_data.operation inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};

    // JALR jumps relative to rs1, everything else relative to the PC
    assign jump_base = is_jalr ? issue_i.fu_data.operand_a[VLEN-1:0] : pc;

    always_comb begin
        target_address = jump_base + issue_i.fu_data.imm[VLEN-1:0];
        // JALR drops the LSB of the sum
        if (is_jalr) begin
            target_address[0] = 1'b0;
        end
    end

    // Fall-through address, also the link value
    assign next_pc = pc + (issue_i.is_compressed ? VLEN'(2) : VLEN'(4));
    assign link_o  = next_pc;

    assign resolve_branch_o = valid_i;

    always_comb begin
        resolved_o         = '0;
        resolved_o.valid   = valid_i;
        resolved_o.pc[VLEN-1:0] = pc;
        // JAL keeps whatever the front end predicted
        resolved_o.cf_type = issue_i.predict.cf;
        if (valid_i) begin
            resolved_o.is_taken = comp_res_i;
            resolved_o.target_address[VLEN-1:0] = comp_res_i ? target_address : next_pc;
            // Conditional branch: direction must match the prediction
            if (is_branch) begin
                resolved_o.cf_type       = Branch;
                resolved_o.is_mispredict = comp_res_i != (issue_i.predict.cf == Branch);
            end
            // JALR: unpredicted or wrong target
            if (is_jalr && (issue_i.predict.cf == NoCF || target_address != predict_address)) begin
                resolved_o.is_mispredict = 1'b1;
                // Returns are tracked by the RAS, not the BTB
                if (issue_i.predict.cf != Return) begin
                    resolved_o.cf_type = JumpR;
                end
            end
        end
    end

    // Jumps always go, branches only when the condition holds
    assign jump_taken = !is_branch || comp_res_i;

    always_comb begin
        exception_o       = '0;
        exception_o.cause = INSTR_ADDR_MISALIGNED;
        exception_o.tval[VLEN-1:0] = pc;
        // Without compressed support targets must be 4-byte aligned
        if (!RVC_EN && valid_i && jump_taken && (target_address[1:0] != 2'b00)) begin
            exception_o.valid = 1'b1;
        end
    end

    assign redirect_o = resolved_o.is_mispredict | exception_o.valid;

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(resolve_branch_o) |-> valid_i)
    else $error("branch_unit: resolve without a valid instruction");

endmodule

//--- design/bru_ctrl.sv
`timescale 1ns/1ps

module bru_ctrl import bru_pkg::*; #(
    parameter int unsigned SHADOW_DEPTH = 1
) (
    input  logic clk_i,
    input  logic rst_n_i,
    // Misprediction or exception in the execute stage
    input  logic redirect_i,
    // Operand register may take the offered slot
    output logic capture_en_o,
    // One-cycle flush toward the front end
    output logic flush_o
);

    localparam int unsigned CNT_W = $clog2(SHADOW_DEPTH + 1);

    ctrl_state_e      state_q;
    ctrl_state_e      state_d;
    // Remaining squashed slots in the shadow
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;

    always_comb begin
        state_d      = state_q;
        cnt_d        = cnt_q;
        capture_en_o = 1'b1;
        flush_o      = 1'b0;
        case (state_q)
            RUN: begin
                if (redirect_i) begin
                    // Slot sampled at this edge is already wrong-path
                    flush_o      = 1'b1;
                    capture_en_o = 1'b0;
                    cnt_d        = CNT_W'(SHADOW_DEPTH);
                    // Zero depth squashes just the same-edge slot
                    state_d      = (SHADOW_DEPTH != 0) ? SHADOW : RUN;
                end
            end
            SHADOW: begin
                capture_en_o = 1'b0;
                cnt_d        = cnt_q - 1'b1;
                // Last squashed edge
                if (cnt_q == CNT_W'(1)) begin
                    state_d = RUN;
                end
            end
            default: begin
                state_d = RUN;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RUN;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // Nothing valid reaches the unit while squashing
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == SHADOW) |-> !redirect_i)
    else $error("bru_ctrl: redirect while squashing");

endmodule

//--- design/bru_pkg.sv
package bru_pkg;

    // Widest address held by the shared structs
    localparam int unsigned VLEN_MAX = 64;

    // Control-flow operations handled by the branch unit
    typedef enum logic [3:0] {
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } fu_op_e;

    // Control-flow kind, as predicted and as resolved
    typedef enum logic [2:0] {
        NoCF,
        Branch,
        Jump,
        JumpR,
        Return
    } cf_e;

    // Room left for more causes later
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0
    } exc_cause_e;

    // Squash FSM states
    typedef enum logic [0:0] {
        RUN,
        SHADOW
    } ctrl_state_e;

    // Issue payload
    typedef struct packed {
        fu_op_e                      operation;
        logic [VLEN_MAX-1:0]         operand_a;
        logic [VLEN_MAX-1:0]         operand_b;
        logic signed [VLEN_MAX-1:0]  imm;
    } fu_data_t;

    // Front-end prediction
    typedef struct packed {
        cf_e                 cf;
        logic [VLEN_MAX-1:0] predict_address;
    } branchpredict_t;

    // Resolution record back to the front end
    typedef struct packed {
        logic                valid;
        logic [VLEN_MAX-1:0] pc;
        logic [VLEN_MAX-1:0] target_address;
        logic                is_taken;
        logic                is_mispredict;
        cf_e                 cf_type;
    } bp_resolve_t;

    typedef struct packed {
        logic                valid;
        exc_cause_e          cause;
        logic [VLEN_MAX-1:0] tval;
    } exception_t;

    // Everything the execute stage needs for one instruction
    typedef struct packed {
        fu_data_t            fu_data;
        logic [VLEN_MAX-1:0] pc;
        logic                is_compressed;
        branchpredict_t      predict;
    } issue_t;

endpackage

//--- design/bru_top.sv
`timescale 1ns/1ps

module bru_top import bru_pkg::*; #(
    parameter int unsigned VLEN         = 32,
    parameter bit          RVC_EN       = 1'b1,
    parameter int unsigned SHADOW_DEPTH = 1
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // Issue port, one instruction per cycle
    input  logic            issue_valid_i,
    input  issue_t          issue_i,
    // Resolution toward the front end
    output bp_resolve_t     resolved_o,
    output logic            resolve_branch_o,
    output logic [VLEN-1:0] link_o,
    output exception_t      exception_o,
    output logic            flush_o
);

    logic   capture_en;
    logic   ex_valid;
    issue_t ex_issue;
    logic   comp_res;
    logic   redirect;

    // Execute-stage register
    operand_stage stage_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .capture_en_i  (capture_en),
        .ex_valid_o    (ex_valid),
        .ex_issue_o    (ex_issue)
    );

    branch_compare #(
        .VLEN (VLEN)
    ) compare_i (
        .fu_data_i  (ex_issue.fu_data),
        .comp_res_o (comp_res)
    );

    branch_unit #(
        .VLEN   (VLEN),
        .RVC_EN (RVC_EN)
    ) unit_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .valid_i          (ex_valid),
        .issue_i          (ex_issue),
        .comp_res_i       (comp_res),
        .resolved_o       (resolved_o),
        .resolve_branch_o (resolve_branch_o),
        .link_o           (link_o),
        .exception_o      (exception_o),
        .redirect_o       (redirect)
    );

    // Squash window after each redirect
    bru_ctrl #(
        .SHADOW_DEPTH (SHADOW_DEPTH)
    ) ctrl_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect),
        .capture_en_o (capture_en),
        .flush_o      (flush_o)
    );

endmodule

//--- design/operand_stage.sv
`timescale 1ns/1ps

module operand_stage import bru_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    // Issue slot from the front end, no back-pressure
    input  logic   issue_valid_i,
    input  issue_t issue_i,
    // Low while the control FSM squashes wrong-path slots
    input  logic   capture_en_i,
    // Registered instruction for the execute stage
    output logic   ex_valid_o,
    output issue_t ex_issue_o
);

    logic   accept;
    logic   ex_valid_q;
    issue_t ex_issue_q;

    // Slot is kept only when offered and not squashed
    assign accept = issue_valid_i & capture_en_i;

    // Valid bit is control state
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
        end else begin
            // Squashed slot loads a cleared valid bit
            ex_valid_q <= accept;
        end
    end

    // Payload only moves for accepted slots
    always_ff @(posedge clk_i) begin
        if (accept) begin
            ex_issue_q <= issue_i;
        end
    end

    assign ex_valid_o = ex_valid_q;
    assign ex_issue_o = ex_issue_q;

    // A slot sampled while squashing must never reach the execute stage
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !capture_en_i |=> !ex_valid_o)
    else $error("operand_stage: valid instruction after squashed slot");

endmodule

//--- sim/tb_bru.sv
`timescale 1ns/1ps

module tb_bru import bru_pkg::*; ();

    localparam int unsigned VLEN = 32;
    // Slots lost after a redirect are the same-edge slot plus a shadow of one
    localparam int SQUASH_SLOTS = 2;

    // One table entry with stimulus and expected response
    typedef struct packed {
        issue_t      issue;
        logic [31:0] exp_target;
        logic        exp_taken;
        logic        exp_mis;
        cf_e         exp_cf;
        logic [31:0] exp_link;
        logic        exp_exc;
        logic        squash;
    } row_t;

    logic            clk_i;
    logic            rst_n_i;
    logic            issue_valid_i;
    issue_t          issue_i;
    bp_resolve_t     resolved_o;
    logic            resolve_branch_o;
    logic [VLEN-1:0] link_o;
    exception_t      exception_o;
    logic            flush_o;

    row_t   rows[$];
    integer seed;

    // Compressed support is off so that misaligned targets trap
    bru_top #(
        .VLEN   (VLEN),
        .RVC_EN (1'b0)
    ) dut_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .issue_valid_i    (issue_valid_i),
        .issue_i          (issue_i),
        .resolved_o       (resolved_o),
        .resolve_branch_o (resolve_branch_o),
        .link_o           (link_o),
        .exception_o      (exception_o),
        .flush_o          (flush_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // Reset spans four rising edges and is released on the falling edge after them
    initial begin
        rst_n_i = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s, got %0h, expected %0h",
                $time, what, got, exp));
        end
    endtask

    // Nothing resolves, traps or flushes
    task automatic check_idle(input string when);
        check(32'(resolve_branch_o), 32'd0, {when, ": resolve_branch_o"});
        check(32'(resolved_o.valid), 32'd0, {when, ": resolved valid"});
        check(32'(exception_o.valid), 32'd0, {when, ": exception valid"});
        check(32'(flush_o), 32'd0, {when, ": flush_o"});
    endtask

    task automatic check_row(input row_t r, input int idx);
        string tag;
        tag = $sformatf("row %0d", idx);
        if (r.squash) begin
            check_idle({tag, " squashed"});
        end else begin
            check(32'(resolve_branch_o), 32'd1, {tag, " resolve_branch_o"});
            check(32'(resolved_o.valid), 32'd1, {tag, " resolved valid"});
            check(resolved_o.pc[31:0], r.issue.pc[31:0], {tag, " pc"});
            check(32'(resolved_o.is_taken), 32'(r.exp_taken), {tag, " is_taken"});
            check(resolved_o.target_address[31:0], r.exp_target, {tag, " target"});
            check(32'(resolved_o.is_mispredict), 32'(r.exp_mis), {tag, " is_mispredict"});
            check(32'(resolved_o.cf_type), 32'(r.exp_cf), {tag, " cf_type"});
            check(link_o, r.exp_link, {tag, " link"});
            check(32'(exception_o.valid), 32'(r.exp_exc), {tag, " exception valid"});
            if (r.exp_exc) begin
                check(32'(exception_o.cause), 32'(INSTR_ADDR_MISALIGNED), {tag, " cause"});
                check(exception_o.tval[31:0], r.issue.pc[31:0], {tag, " tval"});
            end
            // Flush in the same cycle as any redirect
            check(32'(flush_o), 32'(r.exp_mis | r.exp_exc), {tag, " flush_o"});
        end
    endtask

    // Appends a row and the squashed slots that follow a redirect
    task automatic add_row(input fu_op_e op, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] imm, input logic [31:0] pc, input int c,
                           input cf_e pcf, input logic [31:0] paddr, input int taken,
                           input logic [31:0] target, input int mis, input cf_e cf,
                           input int exc);
        row_t row;
        row = '0;
        row.issue.fu_data.operation = op;
        row.issue.fu_data.operand_a = {32'h0, a};
        row.issue.fu_data.operand_b = {32'h0, b};
        row.issue.fu_data.imm       = {{32{imm[31]}}, imm};
        row.issue.pc                = {32'h0, pc};
        row.issue.is_compressed     = (c != 0);
        row.issue.predict.cf        = pcf;
        row.issue.predict.predict_address = {32'h0, paddr};
        row.exp_taken  = (taken != 0);
        row.exp_target = target;
        row.exp_mis    = (mis != 0);
        row.exp_cf     = cf;
        // Link skips the 2 or 4 byte instruction
        row.exp_link   = pc + ((c != 0) ? 32'd2 : 32'd4);
        row.exp_exc    = (exc != 0);
        rows.push_back(row);
        if (row.exp_mis || row.exp_exc) begin
            // Offered as valid JALs that must never resolve
            row = '0;
            row.issue.fu_data.operation = JAL;
            row.issue.pc = 64'h0bad;
            row.squash   = 1'b1;
            repeat (SQUASH_SLOTS) rows.push_back(row);
        end
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        rnd = $random(seed);
        //      op    a            b            imm   pc        c pred   paddr t target    m cf     e
        add_row(BEQ,  rnd,         rnd,         16,   32'h100,  0, Branch, 0, 1, 32'h110,  0, Branch, 0);
        add_row(BEQ,  rnd,         rnd ^ 32'h1, 16,   32'h104,  0, NoCF,   0, 0, 32'h108,  0, Branch, 0);
        rnd = $random(seed);
        add_row(BNE,  rnd,         rnd ^ 32'h1, -8,   32'h108,  0, Branch, 0, 1, 32'h100,  0, Branch, 0);
        add_row(BNE,  5,           5,           16,   32'h10c,  0, Branch, 0, 0, 32'h110,  1, Branch, 0);
        // Signed and unsigned order differ for all-ones
        add_row(BLT,  32'hffffffff, 1,          32,   32'h200,  0, NoCF,   0, 1, 32'h220,  1, Branch, 0);
        add_row(BLT,  1,           32'hffffffff, 32,  32'h204,  0, NoCF,   0, 0, 32'h208,  0, Branch, 0);
        add_row(BGE,  1,           32'hffffffff, -4,  32'h208,  0, Branch, 0, 1, 32'h204,  0, Branch, 0);
        add_row(BGE,  32'hffffffff, 1,          -4,   32'h20c,  0, NoCF,   0, 0, 32'h210,  0, Branch, 0);
        add_row(BLTU, 1,           32'hffffffff, 64,  32'h300,  0, Branch, 0, 1, 32'h340,  0, Branch, 0);
        add_row(BLTU, 32'hffffffff, 1,          64,   32'h304,  0, NoCF,   0, 0, 32'h308,  0, Branch, 0);
        add_row(BGEU, 32'hffffffff, 1,          8,    32'h308,  0, Branch, 0, 1, 32'h310,  0, Branch, 0);
        add_row(BGEU, 1,           32'hffffffff, 8,   32'h30c,  0, Branch, 0, 0, 32'h310,  1, Branch, 0);
        // JAL copies the prediction
        // Compressed PC gives a link of pc+2
        add_row(JAL,  0,           0,           'h40, 32'h400,  0, Jump,   0, 1, 32'h440,  0, Jump,   0);
        add_row(JAL,  0,           0,           'h3e, 32'h402,  1, Jump,   0, 1, 32'h440,  0, Jump,   0);
        // Odd sum 0x2005 loses bit 0
        add_row(JALR, 32'h2001,    0,           4,    32'h500,  0, JumpR, 'h2004, 1, 32'h2004, 0, JumpR, 0);
        add_row(JALR, 32'h3000,    0,           8,    32'h504,  1, JumpR, 'h3000, 1, 32'h3008, 1, JumpR, 0);
        add_row(JALR, 32'h3000,    0,           0,    32'h508,  0, NoCF,  'h3000, 1, 32'h3000, 1, JumpR, 0);
        add_row(JALR, 32'h4000,    0,           'h10, 32'h50c,  0, Return, 0, 1, 32'h4010, 1, Return, 0);
        // Target ending in 2 traps only when taken
        add_row(BEQ,  7,           7,           'h12, 32'h600,  0, Branch, 0, 1, 32'h612,  0, Branch, 1);
        add_row(BEQ,  7,           8,           'h12, 32'h604,  0, NoCF,   0, 0, 32'h608,  0, Branch, 0);
    endtask

    initial begin
        int waited;
        int quiet;
        int i;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        seed          = 32'h29f93bc4;
        build_table();
        waited = 0;
        while (rst_n_i !== 1'b1) begin
            @(posedge clk_i);
            waited++;
            if (waited > 10) begin
                stop_run("Timeout: reset was never released");
            end
            if (rst_n_i === 1'b0) begin
                check_idle("during reset");
            end
        end
        // Drive one row per falling edge and check the previous row's response
        for (i = 0; i <= rows.size(); i++) begin
            @(negedge clk_i);
            if (i == 0) begin
                check_idle("before first row");
            end else begin
                check_row(rows[i - 1], i - 1);
            end
            if (i < rows.size()) begin
                issue_valid_i = 1'b1;
                issue_i       = rows[i].issue;
            end else begin
                issue_valid_i = 1'b0;
                issue_i       = '0;
            end
        end
        // Let any squash window run out
        waited = 0;
        quiet  = 0;
        while (quiet < SQUASH_SLOTS) begin
            @(negedge clk_i);
            waited++;
            if (waited > 20) begin
                stop_run("Timeout: outputs did not go quiet after the last row");
            end
            quiet = (resolve_branch_o || flush_o) ? 0 : quiet + 1;
        end
        $display("Regression passed");
        $finish;
    end

endmodule
